// File: Makefile
# Verilator build for the disk-controller register subsystem

VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing --assert
TOP       = rhControllerTb
RTL_TOP   = rhController
FILELIST  = rhController.f
OBJDIR    = obj_dir
SOURCES   = $(shell grep -v '^+' $(FILELIST)) hdl/rhRegs_consts.svh

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJDIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# Fails unless the pass message shows up in the output
sim: $(OBJDIR)/V$(TOP)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf $(OBJDIR)

// File: bench/rhControllerTb.sv
// Trace-driven testbench for the disk-controller register subsystem
// Replays bench/rhController_trace.txt over the Wishbone port and checks
// read data and the attention line against the trace's expected values

`default_nettype none

module rhControllerTb;

   timeunit 1ns;
   timeprecision 1ps;

   // Cycle limits for each kind of wait
   localparam int ackTimeout = 20;
   localparam int attnTimeout = 100;

   logic        clk;
   logic        rst;
   logic        cyc;
   logic        stb;
   logic        we;
   logic [1:0]  adr;
   logic [1:0]  sel;
   logic [15:0] datI;
   logic [15:0] datO;
   logic        ack;
   logic        busInit;
   logic        memWriteCheckErr;
   logic        memNonexist;
   logic        attn;

   int errCount;
   int testErrs;
   int testChecks;
   int testsRun;
   int testsFailed;
   bit aborted;

   rhController rhController_i (
      .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr), .sel(sel),
      .datI(datI), .datO(datO), .ack(ack), .busInit(busInit),
      .memWriteCheckErr(memWriteCheckErr), .memNonexist(memNonexist), .attn(attn)
   );

   // 10 ns clock
   always #5 clk = ~clk;

   ////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////

   // Register behind each word address
   function automatic string regName(input int a);
      case (a)
         0:       return "datO (CS1)";
         1:       return "datO (CS2)";
         2:       return "datO (DS)";
         default: return "datO (AS)";
      endcase
   endfunction

   // One Wishbone classic transfer, inputs change on the falling edge
   task automatic busTransfer(input logic wr, input logic [1:0] a, input logic [1:0] s,
                              input logic [15:0] d, output logic [15:0] rd);
      int waitCnt;
      bit gotAck;
      waitCnt = 0;
      gotAck = 1'b0;
      rd = '0;
      @(negedge clk);
      cyc = 1'b1;
      stb = 1'b1;
      we = wr;
      adr = a;
      sel = s;
      datI = d;
      // Hold the request until ack
      while (!gotAck && waitCnt < ackTimeout)
      begin
         @(negedge clk);
         waitCnt++;
         if (ack)
         begin
            gotAck = 1'b1;
            rd = datO;
         end
      end
      if (!gotAck)
      begin
         $display("Timeout at %0t: no ack for the transfer to address %0d", $time, a);
         errCount++;
         testErrs++;
         aborted = 1'b1;
      end
      else
      begin
         // Strobe still held one cycle past ack, a second ack would repeat the transfer
         @(negedge clk);
         testChecks++;
         assert (ack == 1'b0)
         else
         begin
            $display("[FAIL] %0t ack expected 0 got %b", $time, ack);
            errCount++;
            testErrs++;
         end
      end
      cyc = 1'b0;
      stb = 1'b0;
      we = 1'b0;
   endtask

   task automatic compareMasked(input string name, input logic [15:0] act,
                                input logic [15:0] exp, input logic [15:0] mask);
      testChecks++;
      assert ((act & mask) == (exp & mask))
      else
      begin
         $display("[FAIL] %0t %s expected %h got %h", $time, name, exp & mask, act & mask);
         errCount++;
         testErrs++;
      end
   endtask

   // Single-cycle memory error report, bit 0 write check, bit 1 nonexistent
   task automatic pulseErrors(input logic [1:0] which);
      @(negedge clk);
      memWriteCheckErr = which[0];
      memNonexist = which[1];
      @(negedge clk);
      memWriteCheckErr = 1'b0;
      memNonexist = 1'b0;
   endtask

   task automatic waitAttn(input logic level);
      int waitCnt;
      waitCnt = 0;
      while (attn !== level && waitCnt < attnTimeout)
      begin
         @(negedge clk);
         waitCnt++;
      end
      testChecks++;
      assert (attn === level)
      else
      begin
         $display("Timeout at %0t: attn did not reach %b in %0d cycles", $time, level,
                  attnTimeout);
         errCount++;
         testErrs++;
         aborted = 1'b1;
      end
   endtask

   task automatic finishTest(input int num);
      testsRun++;
      if (testErrs != 0)
         testsFailed++;
      $display("Test %0d: %0d checks, %0d errors, %s", num, testChecks, testErrs,
               (testErrs == 0) ? "pass" : "fail");
   endtask

   ////////////////////////////////////////////////////////////
   // Trace replay
   ////////////////////////////////////////////////////////////

   initial
   begin
      int          fd;
      int          n;
      int          curTest;
      int          tst;
      int          op;
      int          a;
      int          s;
      logic [15:0] d;
      logic [15:0] e;
      logic [15:0] m;
      logic [15:0] rd;
      string       line;
      $timeformat(-9, 0, " ns", 0);
      clk = 1'b0;
      rst = 1'b1;
      cyc = 1'b0;
      stb = 1'b0;
      we = 1'b0;
      adr = '0;
      sel = '0;
      datI = '0;
      busInit = 1'b0;
      memWriteCheckErr = 1'b0;
      memNonexist = 1'b0;
      errCount = 0;
      testErrs = 0;
      testChecks = 0;
      testsRun = 0;
      testsFailed = 0;
      aborted = 1'b0;
      curTest = 0;
      // Reset for 10 cycles
      for (int i = 0; i < 10; i++)
         @(negedge clk);
      rst = 1'b0;
      fd = $fopen("bench/rhController_trace.txt", "r");
      if (fd == 0)
      begin
         $display("The trace file bench/rhController_trace.txt could not be opened");
         errCount++;
         aborted = 1'b1;
      end
      else
      begin
         while (!aborted && !$feof(fd))
         begin
            line = "";
            void'($fgets(line, fd));
            n = $sscanf(line, "%h %h %h %h %h %h %h", tst, op, a, s, d, e, m);
            // Comment and blank lines fall through
            if (line.len() > 0 && line.getc(0) != "#" && n == 7)
            begin
               if (tst != curTest)
               begin
                  if (curTest != 0)
                     finishTest(curTest);
                  curTest = tst;
                  testErrs = 0;
                  testChecks = 0;
               end
               case (op)
                  0: busTransfer(1'b1, a[1:0], s[1:0], d, rd);
                  1:
                  begin
                     busTransfer(1'b0, a[1:0], s[1:0], d, rd);
                     if (!aborted)
                        compareMasked(regName(a), rd, e, m);
                  end
                  2: pulseErrors(d[1:0]);
                  3: waitAttn(e[0]);
                  default:
                  begin
                     $display("Unknown operation code %0d in the trace", op);
                     errCount++;
                     testErrs++;
                  end
               endcase
            end
         end
         $fclose(fd);
      end
      if (curTest != 0)
         finishTest(curTest);
      $display("Tests run: %0d, tests failed: %0d, errors: %0d", testsRun, testsFailed,
               errCount);
      if (errCount == 0 && !aborted)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: bench/rhController_trace.txt
# Columns in hex: test op adr sel data expect mask
# op 0 write, 1 read and compare under mask, 2 error pulse (data bit0 WCE, bit1 NEM), 3 wait attn = expect bit0
# Test 1, state after reset
1 1 0 3 0000 0080 ffff
1 1 1 3 0000 0000 ffff
1 1 2 3 0000 0080 ffff
1 1 3 3 0000 0000 ffff
# Test 2, CS2 low byte, high byte and CLR
2 0 1 1 001b 0000 0000
2 1 1 3 0000 001b ffff
2 0 1 2 2200 0000 0000
2 1 1 3 0000 221b ffff
2 0 1 1 0020 0000 0000
2 1 1 3 0000 0000 ffff
# Test 3, GO function 5 on unit 1, then clear its attention
3 0 1 1 0001 0000 0000
3 0 0 1 000b 0000 0000
3 1 0 3 0000 000b ffff
3 3 0 0 0000 0001 0000
3 1 0 3 0000 008a ffff
3 1 3 3 0000 0002 ffff
3 1 2 3 0000 8080 ffff
3 0 3 1 0002 0000 0000
3 3 0 0 0000 0000 0000
3 1 3 3 0000 0000 ffff
# Test 4, PGE from GO while busy
4 0 1 1 0000 0000 0000
4 0 0 1 000b 0000 0000
4 0 0 1 000b 0000 0000
4 1 1 3 0000 0400 ffff
4 3 0 0 0000 0001 0000
4 0 3 1 0001 0000 0000
4 3 0 0 0000 0000 0000
# Test 4, NED from unit 5, memory errors, TRE clear
4 0 1 1 0005 0000 0000
4 0 0 1 000b 0000 0000
4 1 1 3 0000 1405 ffff
4 2 0 0 0003 0000 0000
4 1 1 3 0000 5c05 ffff
4 0 0 2 4000 0000 0000
4 1 1 3 0000 0005 ffff
4 1 0 3 0000 008a ffff
# Test 4, later GO clears WCE and NEM but keeps PGE
4 0 1 1 0000 0000 0000
4 0 0 1 000b 0000 0000
4 0 0 1 000b 0000 0000
4 2 0 0 0003 0000 0000
4 3 0 0 0000 0001 0000
4 1 1 3 0000 4c00 ffff
4 0 3 1 0001 0000 0000
4 3 0 0 0000 0000 0000
4 0 0 1 000b 0000 0000
4 1 1 3 0000 0400 ffff
4 3 0 0 0000 0001 0000
4 0 3 1 0001 0000 0000
4 3 0 0 0000 0000 0000
# Test 5, function code 0 on unit 2 sets ERR, next GO clears it
5 0 1 1 0002 0000 0000
5 0 0 1 0001 0000 0000
5 3 0 0 0000 0001 0000
5 1 2 3 0000 c080 ffff
5 0 3 1 0004 0000 0000
5 3 0 0 0000 0000 0000
5 1 2 3 0000 4080 ffff
5 0 0 1 000b 0000 0000
5 1 2 3 0000 0000 ffff
5 3 0 0 0000 0001 0000
5 1 2 3 0000 8080 ffff
5 0 3 1 0004 0000 0000
5 3 0 0 0000 0000 0000
# Test 6, DS of a missing unit reads zero
6 0 1 1 0007 0000 0000
6 1 2 3 0000 0000 ffff
6 0 1 1 0003 0000 0000
6 1 2 3 0000 0080 ffff

// File: hdl/rhBusSlave.sv
// Wishbone classic slave for the register subsystem
// Decodes address and byte selects onto the register bus, acks once per strobe
// and registers the read word on the ack edge

`default_nettype none

`include "rhRegs_consts.svh"

module rhBusSlave
   import rhPkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        cyc,
   input  logic        stb,
   input  logic        we,
   input  logic [1:0]  adr,
   input  logic [1:0]  sel,
   input  logic [15:0] datI,
   output logic [15:0] datO,
   output logic        ack,
   rhRegBus.slave      regBus,
   input  logic [15:0] cs1Read,
   input  logic [15:0] cs2Read,
   input  logic [15:0] dsRead,
   input  logic [15:0] asRead
);

   logic        req;
   logic        served;
   logic        accept;
   logic [15:0] rdWord;

   ////////////////////////////////////////////////////////////
   // Handshake
   ////////////////////////////////////////////////////////////

   assign req = cyc & stb;
   // New request, not yet acked in this strobe
   assign accept = req & ~served;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         ack <= 1'b0;
         served <= 1'b0;
      end
      else
      begin
         ack <= accept;
         // Set on the ack edge, stays set while the master holds stb
         served <= req & (served | accept);
      end
   end

   ////////////////////////////////////////////////////////////
   // Decode
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      case (adr)
         `RH_ADDR_CS1: regBus.regSel = regCs1;
         `RH_ADDR_CS2: regBus.regSel = regCs2;
         `RH_ADDR_DS:  regBus.regSel = regDs;
         `RH_ADDR_AS:  regBus.regSel = regAs;
         default:      regBus.regSel = regNone;
      endcase
   end

   // Write lands on the same edge that raises ack
   assign regBus.wrStb = accept & we;
   assign regBus.loByte = sel[0];
   assign regBus.hiByte = sel[1];
   assign regBus.wrData = datI;

   // Read word, unmapped reads zero
   always_comb
   begin
      case (regBus.regSel)
         regCs1:  rdWord = cs1Read;
         regCs2:  rdWord = cs2Read;
         regDs:   rdWord = dsRead;
         regAs:   rdWord = asRead;
         default: rdWord = '0;
      endcase
   end

   // Captures state as it stood before the ack edge
   always_ff @(posedge clk)
   begin
      if (accept)
         datO <= rdWord;
   end

   // One ack per strobe, never back to back
   ackSingle: assert property (@(posedge clk) disable iff (rst) ack |=> !ack);

endmodule

`default_nettype wire

// File: hdl/rhController.sv
// Top level of the disk-controller register subsystem
// Wishbone classic port, memory error inputs, device reset and attention out
// Wires the bus slave, CS1, CS2, status mux and the row of drives

`default_nettype none

`include "rhRegs_consts.svh"

module rhController
   import rhPkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        cyc,
   input  logic        stb,
   input  logic        we,
   input  logic [1:0]  adr,
   input  logic [1:0]  sel,
   input  logic [15:0] datI,
   output logic [15:0] datO,
   output logic        ack,
   input  logic        busInit,
   input  logic        memWriteCheckErr,
   input  logic        memNonexist,
   output logic        attn
);

   logic [15:0]                   cs1Read;
   logic [15:0]                   cs2Read;
   logic [15:0]                   dsRead;
   logic [15:0]                   asRead;
   logic                          goStart;
   logic                          setPge;
   logic                          treClr;
   logic                          doneAny;
   logic [2:0]                    unit;
   driveFuncT                     func;
   driveStatT [`RH_NUM_DRIVES-1:0] stat;
   logic [`RH_NUM_DRIVES-1:0]     done;
   logic [`RH_NUM_DRIVES-1:0]     ataClr;

   rhRegBus regBus ();

   rhBusSlave rhBusSlave_i (
      .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr), .sel(sel),
      .datI(datI), .datO(datO), .ack(ack), .regBus(regBus.slave),
      .cs1Read(cs1Read), .cs2Read(cs2Read), .dsRead(dsRead), .asRead(asRead)
   );

   rhCs1 rhCs1_i (
      .clk(clk), .rst(rst), .busInit(busInit), .regBus(regBus.target),
      .doneAny(doneAny), .cs1Read(cs1Read), .goStart(goStart), .func(func),
      .setPge(setPge), .treClr(treClr)
   );

   // BAI gate follows CS1 ready
   rhCs2 rhCs2_i (
      .clk(clk), .rst(rst), .busInit(busInit), .regBus(regBus.target),
      .goStart(goStart), .setPge(setPge), .treClr(treClr),
      .memWriteCheckErr(memWriteCheckErr), .memNonexist(memNonexist),
      .rdy(cs1Read[`RH_CS1_RDY]), .cs2Read(cs2Read), .unit(unit)
   );

   rhStatusMux rhStatusMux_i (
      .clk(clk), .rst(rst), .regBus(regBus.target), .unit(unit), .stat(stat),
      .done(done), .dsRead(dsRead), .asRead(asRead), .ataClr(ataClr),
      .doneAny(doneAny), .attn(attn)
   );

   ////////////////////////////////////////////////////////////
   // Drive row
   ////////////////////////////////////////////////////////////

   for (genvar i = 0; i < `RH_NUM_DRIVES; i++)
   begin : gDrive
      rhDrive #(
         .unitIdx(i)
      ) rhDrive_i (
         .clk(clk), .rst(rst), .busInit(busInit), .goStart(goStart), .func(func),
         .unit(unit), .ataClr(ataClr[i]), .stat(stat[i]), .done(done[i])
      );
   end

endmodule

`default_nettype wire

// File: hdl/rhCs1.sv
// CS1 control and status register
// Holds function code and RDY, starts drive functions on GO and flags
// GO while busy as a program error

`default_nettype none

`include "rhRegs_consts.svh"

module rhCs1
   import rhPkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        busInit,
   rhRegBus.target     regBus,
   input  logic        doneAny,
   output logic [15:0] cs1Read,
   output logic        goStart,
   output driveFuncT   func,
   output logic        setPge,
   output logic        treClr
);

   logic      cs1Wr;
   logic      loWr;
   logic      goWr;
   logic      rdy;
   driveFuncT funcReg;

   ////////////////////////////////////////////////////////////
   // Write decode
   ////////////////////////////////////////////////////////////

   assign cs1Wr = regBus.wrStb && (regBus.regSel == regCs1);
   assign loWr = cs1Wr & regBus.loByte;
   assign goWr = loWr & regBus.wrData[`RH_CS1_GO];

   // GO starts only when idle, otherwise a program error
   assign goStart = goWr & rdy;
   assign setPge = goWr & ~rdy;
   assign treClr = cs1Wr & regBus.hiByte & regBus.wrData[`RH_CS1_TRE];

   // Drives see the code written alongside GO
   assign func = (loWr & rdy) ? regBus.wrData[`RH_CS1_FUNC_HI:`RH_CS1_FUNC_LO] : funcReg;

   ////////////////////////////////////////////////////////////
   // State
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst || busInit)
      begin
         funcReg <= '0;
         rdy <= 1'b1;
      end
      else
      begin
         // Function field frozen while a function runs
         if (loWr & rdy)
            funcReg <= regBus.wrData[`RH_CS1_FUNC_HI:`RH_CS1_FUNC_LO];
         if (goStart)
            rdy <= 1'b0;
         else if (doneAny | treClr)
            rdy <= 1'b1;   // TRE also aborts a function with no drive behind it
      end
   end

   // Readback, GO shows a function in progress
   always_comb
   begin
      cs1Read = '0;
      cs1Read[`RH_CS1_GO] = ~rdy;
      cs1Read[`RH_CS1_FUNC_HI:`RH_CS1_FUNC_LO] = funcReg;
      cs1Read[`RH_CS1_RDY] = rdy;
   end

   // Busy with no completion pending, so no GO next cycle
   goWhileBusy: assert property (@(posedge clk) disable iff (rst || busInit)
      (!rdy && !doneAny && !treClr) |=> !goStart);

endmodule

`default_nettype wire

// File: hdl/rhCs2.sv
// CS2 control and status register
// Error flags from memory reports and GO checks, controller clear,
// parity test, address-increment inhibit and unit select

`default_nettype none

`include "rhRegs_consts.svh"

module rhCs2
   import rhPkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        busInit,
   rhRegBus.target     regBus,
   input  logic        goStart,
   input  logic        setPge,
   input  logic        treClr,
   input  logic        memWriteCheckErr,
   input  logic        memNonexist,
   input  logic        rdy,
   output logic [15:0] cs2Read,
   output logic [2:0]  unit
);

   logic cs2Wr;
   logic hiWr;
   logic loWr;
   logic clr;
   logic errClr;
   logic unitMissing;
   logic wce;
   logic upe;
   logic ned;
   logic nem;
   logic pge;
   logic mxf;
   logic pat;
   logic bai;

   assign cs2Wr = regBus.wrStb && (regBus.regSel == regCs2);
   assign hiWr = cs2Wr & regBus.hiByte;
   assign loWr = cs2Wr & regBus.loByte;

   // Controller clear, write-only pulse
   assign clr = loWr & regBus.wrData[`RH_CS2_CLR];
   assign errClr = busInit | clr | treClr;
   assign unitMissing = int'(unit) >= `RH_NUM_DRIVES;

   ////////////////////////////////////////////////////////////
   // Error flags
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wce <= 1'b0;
         upe <= 1'b0;
         ned <= 1'b0;
         nem <= 1'b0;
         pge <= 1'b0;
         mxf <= 1'b0;
      end
      else
      begin
         // Write check error from memory side
         if (errClr | goStart)
            wce <= 1'b0;
         else if (memWriteCheckErr)
            wce <= 1'b1;
         // Non-existent memory
         if (errClr | goStart)
            nem <= 1'b0;
         else if (memNonexist)
            nem <= 1'b1;
         // GO to a unit past the last drive sets NED, any other GO clears it
         if (errClr)
            ned <= 1'b0;
         else if (goStart)
            ned <= unitMissing;
         // Program error survives GO
         if (errClr)
            pge <= 1'b0;
         else if (setPge)
            pge <= 1'b1;
         // UPE and MXF only settable by software
         if (errClr | goStart)
         begin
            upe <= 1'b0;
            mxf <= 1'b0;
         end
         else if (hiWr)
         begin
            upe <= regBus.wrData[`RH_CS2_UPE];
            mxf <= regBus.wrData[`RH_CS2_MXF];
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Control fields
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst || busInit || clr)
      begin
         pat <= 1'b0;
         bai <= 1'b0;
         unit <= '0;
      end
      else if (loWr)
      begin
         pat <= regBus.wrData[`RH_CS2_PAT];
         unit <= regBus.wrData[`RH_CS2_UNIT_HI:`RH_CS2_UNIT_LO];
         // Inhibit only changes between functions
         if (rdy)
            bai <= regBus.wrData[`RH_CS2_BAI];
      end
   end

   // Unimplemented flags and CLR read zero
   always_comb
   begin
      cs2Read = '0;
      cs2Read[`RH_CS2_WCE] = wce;
      cs2Read[`RH_CS2_UPE] = upe;
      cs2Read[`RH_CS2_NED] = ned;
      cs2Read[`RH_CS2_NEM] = nem;
      cs2Read[`RH_CS2_PGE] = pge;
      cs2Read[`RH_CS2_MXF] = mxf;
      cs2Read[`RH_CS2_PAT] = pat;
      cs2Read[`RH_CS2_BAI] = bai;
      cs2Read[`RH_CS2_UNIT_HI:`RH_CS2_UNIT_LO] = unit;
   end

endmodule

`default_nettype wire

// File: hdl/rhDrive.sv
// One drive unit
// Accepts GO when the selected unit matches its index, stays busy for a
// fixed time, then raises attention and ready with a one-cycle done pulse

`default_nettype none

`include "rhRegs_consts.svh"

module rhDrive
   import rhPkg::*;
#(
   parameter int unitIdx = 0
)
(
   input  logic      clk,
   input  logic      rst,
   input  logic      busInit,
   input  logic      goStart,
   input  driveFuncT func,
   input  logic [2:0] unit,
   input  logic      ataClr,
   output driveStatT stat,
   output logic      done
);

   localparam int cntWidth = $clog2(`RH_FUNC_CYCLES + 1);

   logic                accept;
   logic                finish;
   logic                ata;
   logic                err;
   logic                dry;
   logic [cntWidth-1:0] cnt;
   driveFuncT           funcReg;

   assign accept = goStart && (unit == 3'(unitIdx));
   // Last busy cycle
   assign finish = ~dry && (cnt == '0);

   always_ff @(posedge clk)
   begin
      if (rst || busInit)
      begin
         ata <= 1'b0;
         err <= 1'b0;
         dry <= 1'b1;
         done <= 1'b0;
         cnt <= '0;
      end
      else
      begin
         done <= finish;
         if (accept)
         begin
            dry <= 1'b0;
            err <= 1'b0;
            cnt <= cntWidth'(`RH_FUNC_CYCLES - 1);
         end
         else if (finish)
         begin
            dry <= 1'b1;
            err <= (funcReg == '0);   // Code 0 is not a function
         end
         else if (!dry)
            cnt <= cnt - 1'b1;
         // Attention set wins over a clear in the same cycle
         if (finish)
            ata <= 1'b1;
         else if (ataClr)
            ata <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
         funcReg <= func;
   end

   assign stat = '{ata: ata, err: err, dry: dry};

endmodule

`default_nettype wire

// File: hdl/rhPkg.sv
// Types shared by the register blocks, the drives and the status mux
// Import with a wildcard in the module header where a type is needed

`default_nettype none

package rhPkg;

   ////////////////////////////////////////////////////////////
   // Register select
   ////////////////////////////////////////////////////////////

   // Register addressed by the current bus cycle
   // regNone marks an address with no register behind it
   typedef enum logic [2:0]
   {
      regCs1,
      regCs2,
      regDs,
      regAs,
      regNone
   } regSelT;

   ////////////////////////////////////////////////////////////
   // Drive side
   ////////////////////////////////////////////////////////////

   // Status of one drive
   typedef struct packed
   {
      logic ata;   // Attention, function finished
      logic err;   // Last function failed
      logic dry;   // Drive ready, no function running
   } driveStatT;

   // Function code as written to CS1
   typedef logic [4:0] driveFuncT;

endpackage

`default_nettype wire

// File: hdl/rhRegBus.sv
// Decoded register write path from the bus slave to the register blocks
// The slave modport drives it, each register block takes the target modport

`default_nettype none

interface rhRegBus
   import rhPkg::*;
();

   // One-cycle write strobe, lines up with the ack edge
   logic        wrStb;
   // Register named by the bus address
   regSelT      regSel;
   // Byte lanes taking part in the write
   logic        loByte;
   logic        hiByte;
   // Write data straight from the bus
   logic [15:0] wrData;

   modport slave
   (
      output wrStb,
      output regSel,
      output loByte,
      output hiByte,
      output wrData
   );

   modport target
   (
      input wrStb,
      input regSel,
      input loByte,
      input hiByte,
      input wrData
   );

endinterface

`default_nettype wire

// File: hdl/rhRegs_consts.svh
// Shared constants for the disk-controller register subsystem
// Register word addresses, register bit positions, drive count and timing
// Include after `default_nettype in any file that needs them
`ifndef RH_REGS_CONSTS_SVH
`define RH_REGS_CONSTS_SVH

// Drive population and function length in clock cycles
`define RH_NUM_DRIVES 4
`define RH_FUNC_CYCLES 6

// Word addresses on the Wishbone port
`define RH_ADDR_CS1 2'd0
`define RH_ADDR_CS2 2'd1
`define RH_ADDR_DS 2'd2
`define RH_ADDR_AS 2'd3

// CS1 fields
`define RH_CS1_GO 0
`define RH_CS1_FUNC_LO 1
`define RH_CS1_FUNC_HI 5
`define RH_CS1_RDY 7
`define RH_CS1_TRE 14

// CS2 fields
`define RH_CS2_WCE 14
`define RH_CS2_UPE 13
`define RH_CS2_NED 12
`define RH_CS2_NEM 11
`define RH_CS2_PGE 10
`define RH_CS2_MXF 9
`define RH_CS2_CLR 5
`define RH_CS2_PAT 4
`define RH_CS2_BAI 3
`define RH_CS2_UNIT_HI 2
`define RH_CS2_UNIT_LO 0

// Drive status fields
`define RH_DS_ATA 15
`define RH_DS_ERR 14
`define RH_DS_DRY 7

`endif

// File: hdl/rhStatusMux.sv
// Drive status gathering
// Drive status word for the selected unit, attention summary with
// write-one-to-clear, completion OR and the attention line

`default_nettype none

`include "rhRegs_consts.svh"

module rhStatusMux
   import rhPkg::*;
(
   input  logic                          clk,
   input  logic                          rst,
   rhRegBus.target                       regBus,
   input  logic [2:0]                    unit,
   input  driveStatT [`RH_NUM_DRIVES-1:0] stat,
   input  logic [`RH_NUM_DRIVES-1:0]     done,
   output logic [15:0]                   dsRead,
   output logic [15:0]                   asRead,
   output logic [`RH_NUM_DRIVES-1:0]     ataClr,
   output logic                          doneAny,
   output logic                          attn
);

   logic asWr;
   logic ataAny;

   assign asWr = regBus.wrStb && (regBus.regSel == regAs);

   always_comb
   begin
      dsRead = '0;
      asRead = '0;
      ataAny = 1'b0;
      for (int i = 0; i < `RH_NUM_DRIVES; i++)
      begin
         // Missing unit matches nothing and reads zero
         if (unit == 3'(i))
         begin
            dsRead[`RH_DS_ATA] = stat[i].ata;
            dsRead[`RH_DS_ERR] = stat[i].err;
            dsRead[`RH_DS_DRY] = stat[i].dry;
         end
         asRead[i] = stat[i].ata;
         ataAny = ataAny | stat[i].ata;
         // Write one clears, lane follows bit position
         ataClr[i] = asWr && regBus.wrData[i] && ((i < 8) ? regBus.loByte : regBus.hiByte);
      end
   end

   assign doneAny = |done;

   // Registered so the outside line never glitches
   always_ff @(posedge clk)
   begin
      if (rst)
         attn <= 1'b0;
      else
         attn <= ataAny;
   end

endmodule

`default_nettype wire

// File: rhController.f
+incdir+hdl
hdl/rhPkg.sv
hdl/rhRegBus.sv
hdl/rhBusSlave.sv
hdl/rhCs1.sv
hdl/rhCs2.sv
hdl/rhDrive.sv
hdl/rhStatusMux.sv
hdl/rhController.sv
bench/rhControllerTb.sv
